// File: source/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data path and bus width
`define RV_XLEN        32

// general purpose registers x0..x31
`define RV_NR_REGS     32
`define RV_REG_IDX_W   5

// boot address of the program memory
`define RV_PC_RESET    32'h2040_0000

`endif

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

`include "rv_core_defines.svh"

    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    localparam funct3_t F3_JALR    = 3'b000;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_BLTU    = 3'b110;
    localparam funct3_t F3_BGEU    = 3'b111;
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LW      = 3'b010;
    localparam funct3_t F3_SW      = 3'b010;

    localparam funct7_t F7_BASE    = 7'b0000000;
    localparam funct7_t F7_ALT     = 7'b0100000;   // sub and arithmetic shift

    // R-type field layout, the other formats reuse it bit for bit
    typedef struct packed {
        funct7_t  funct7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        funct3_t  funct3;
        reg_idx_t rd;
        opcode_e  opcode;
    } instr_t;

endpackage

// File: source/rv_core_pkg.sv
package rv_core_pkg;

`include "rv_core_defines.svh"

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_PREPARE,
        ST_EXECUTE,
        ST_ACCESS,
        ST_WRITEBACK
    } stage_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [3:0] {
        CLS_NONE,        // unknown encoding, runs as a no-op
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_LOAD,
        CLS_STORE
    } instr_class_e;

endpackage

// File: source/rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
();

    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    instr_class_e iclass;
    alu_op_e      alu_op;
    funct3_t      funct3;   // branch condition select

    modport decoder (
        output rs1, rs2, rd, imm, iclass, alu_op, funct3
    );

    modport sequencer (
        input rd, imm, iclass, funct3
    );

    modport alu (
        input imm, iclass, alu_op
    );

endinterface

// File: source/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_decode_en,
    input  word_t i_instr,
    rv_decode_if.decoder dec
);

    instr_t       fields;
    instr_class_e iclass;
    alu_op_e      alu_op;
    word_t        imm;
    logic         is_shift;
    logic         alt_ok;

    function automatic alu_op_e alu_op_of(funct3_t f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign fields   = i_instr;
    assign is_shift = (fields.funct3 == F3_SLL) || (fields.funct3 == F3_SRL_SRA);
    // funct7 alternate is legal for srai/sra, and for sub on register ops only
    assign alt_ok   = (fields.funct7 == F7_ALT) &&
                      ((fields.funct3 == F3_SRL_SRA) ||
                       (fields.opcode == OPC_OP && fields.funct3 == F3_ADD_SUB));

    always_comb begin
        iclass = CLS_NONE;
        alu_op = ALU_ADD;   // branches and address math
        case (fields.opcode)
            OPC_LUI:   iclass = CLS_LUI;
            OPC_AUIPC: iclass = CLS_AUIPC;
            OPC_JAL:   iclass = CLS_JAL;
            OPC_JALR:  if (fields.funct3 == F3_JALR) iclass = CLS_JALR;
            OPC_LOAD:  if (fields.funct3 == F3_LW) iclass = CLS_LOAD;
            OPC_STORE: if (fields.funct3 == F3_SW) iclass = CLS_STORE;
            OPC_BRANCH: begin
                case (fields.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: iclass = CLS_BRANCH;
                    default: iclass = CLS_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                if (!is_shift || fields.funct7 == F7_BASE || alt_ok) begin
                    iclass = CLS_ALU_IMM;
                    alu_op = alu_op_of(fields.funct3, alt_ok);
                end
            end
            OPC_OP: begin
                if (fields.funct7 == F7_BASE || alt_ok) begin
                    iclass = CLS_ALU_REG;
                    alu_op = alu_op_of(fields.funct3, alt_ok);
                end
            end
            default: iclass = CLS_NONE;
        endcase
    end

    always_comb begin
        case (fields.opcode)
            OPC_STORE:  imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            OPC_BRANCH: imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            OPC_LUI,
            OPC_AUIPC:  imm = {i_instr[31:12], 12'b0};
            OPC_JAL:    imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            default:    imm = {{20{i_instr[31]}}, i_instr[31:20]};   // I-type
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dec.iclass <= CLS_NONE;
        end else if (i_decode_en) begin
            dec.iclass <= iclass;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_decode_en) begin
            dec.rs1    <= fields.rs1;
            dec.rs2    <= fields.rs2;
            dec.rd     <= fields.rd;
            dec.funct3 <= fields.funct3;
            dec.imm    <= imm;
            dec.alu_op <= alu_op;
        end
    end

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_regfile
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_ra,
    input  reg_idx_t i_rb,
    output word_t    o_rdata_a,
    output word_t    o_rdata_b,
    input  logic     i_we,
    input  reg_idx_t i_widx,
    input  word_t    i_wdata
);

    word_t regs [`RV_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_widx != '0) begin   // x0 stays zero
            regs[i_widx] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_ra];
    assign o_rdata_b = regs[i_rb];

endmodule

// File: source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
    import rv_core_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    rv_decode_if.alu dec,
    input  logic  i_prepare_en,
    input  logic  i_execute_en,
    input  word_t i_pc,
    input  word_t i_rs1_data,
    input  word_t i_rs2_data,
    output word_t o_result,
    output logic  o_eq,
    output logic  o_ge,
    output logic  o_geu
);

    word_t op_a;
    word_t op_b;
    word_t cmp_a;
    word_t cmp_b;
    word_t result_d;
    logic  use_pc;

    assign use_pc = (dec.iclass == CLS_AUIPC) || (dec.iclass == CLS_JAL) ||
                    (dec.iclass == CLS_BRANCH);

    always_ff @(posedge i_clk) begin
        if (i_prepare_en) begin
            op_a  <= use_pc ? i_pc : i_rs1_data;
            op_b  <= (dec.iclass == CLS_ALU_REG) ? i_rs2_data : dec.imm;
            cmp_a <= i_rs1_data;
            cmp_b <= i_rs2_data;
        end
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  result_d = op_a - op_b;
            ALU_SLT:  result_d = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result_d = word_t'(op_a < op_b);
            ALU_XOR:  result_d = op_a ^ op_b;
            ALU_OR:   result_d = op_a | op_b;
            ALU_AND:  result_d = op_a & op_b;
            ALU_SLL:  result_d = op_a << op_b[4:0];   // shamt in low bits
            ALU_SRL:  result_d = op_a >> op_b[4:0];
            ALU_SRA:  result_d = $signed(op_a) >>> op_b[4:0];
            default:  result_d = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_execute_en) begin
            o_result <= result_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_eq  <= 1'b0;
            o_ge  <= 1'b0;
            o_geu <= 1'b0;
        end else if (i_execute_en) begin
            o_eq  <= (cmp_a == cmp_b);
            o_ge  <= ($signed(cmp_a) >= $signed(cmp_b));
            o_geu <= (cmp_a >= cmp_b);
        end
    end

endmodule

// File: source/rv_sequencer.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_sequencer
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    rv_decode_if.sequencer dec,
    input  word_t      i_rs2_data,
    output logic       o_rf_we,
    output reg_idx_t   o_rf_widx,
    output word_t      o_rf_wdata,
    output logic       o_decode_en,
    output logic       o_prepare_en,
    output logic       o_execute_en,
    output word_t      o_pc,
    input  word_t      i_alu_result,
    input  logic       i_eq,
    input  logic       i_ge,
    input  logic       i_geu,
    output logic       o_mem_valid,
    input  logic       i_mem_ready,
    output word_t      o_mem_addr,
    input  word_t      i_mem_data,
    output word_t      o_mem_data,
    output logic [3:0] o_mem_wen
);

    stage_e stage;
    word_t  pc;
    word_t  next_pc;
    word_t  rdata;
    word_t  jump_target;
    logic   take_branch;
    logic   writes_rd;
    logic   mem_done;

    assign mem_done    = o_mem_valid && i_mem_ready;
    assign jump_target = {i_alu_result[`RV_XLEN-1:1], 1'b0};   // jalr clears bit 0

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  take_branch = i_eq;
            F3_BNE:  take_branch = !i_eq;
            F3_BLT:  take_branch = !i_ge;
            F3_BGE:  take_branch = i_ge;
            F3_BLTU: take_branch = !i_geu;
            F3_BGEU: take_branch = i_geu;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.iclass)
            CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
            CLS_ALU_IMM, CLS_ALU_REG, CLS_LOAD: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.iclass)
            CLS_LUI:           o_rf_wdata = dec.imm;
            CLS_JAL, CLS_JALR: o_rf_wdata = next_pc;   // link = pc + 4
            CLS_LOAD:          o_rf_wdata = rdata;
            default:           o_rf_wdata = i_alu_result;
        endcase
    end

    assign o_rf_we      = (stage == ST_WRITEBACK) && !o_mem_valid && writes_rd;
    assign o_rf_widx    = dec.rd;
    // the fetch wait is already counted as DECODE, the word is taken with ready
    assign o_decode_en  = (stage == ST_DECODE) && mem_done;
    assign o_prepare_en = (stage == ST_PREPARE);
    assign o_execute_en = (stage == ST_EXECUTE);
    assign o_pc         = pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage       <= ST_FETCH;
            pc          <= `RV_PC_RESET;
            next_pc     <= `RV_PC_RESET;
            o_mem_valid <= 1'b0;
            o_mem_wen   <= '0;
        end else if (o_mem_valid) begin
            if (i_mem_ready) begin   // stage stalls until the bus completes
                o_mem_valid <= 1'b0;
                o_mem_wen   <= '0;
            end
        end else begin
            case (stage)
                ST_FETCH: begin
                    o_mem_valid <= 1'b1;
                    pc          <= next_pc;
                    next_pc     <= next_pc + 4;
                    stage       <= ST_DECODE;
                end
                ST_DECODE:  stage <= ST_PREPARE;
                ST_PREPARE: stage <= ST_EXECUTE;
                ST_EXECUTE: begin
                    if (dec.iclass == CLS_LOAD || dec.iclass == CLS_STORE) begin
                        stage <= ST_ACCESS;
                    end else begin
                        stage <= ST_WRITEBACK;
                    end
                end
                ST_ACCESS: begin
                    o_mem_valid <= 1'b1;
                    if (dec.iclass == CLS_STORE) begin
                        o_mem_wen <= '1;   // word stores only
                        stage     <= ST_FETCH;
                    end else begin
                        stage     <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    if ((dec.iclass == CLS_BRANCH && take_branch) ||
                        dec.iclass == CLS_JAL || dec.iclass == CLS_JALR) begin
                        next_pc <= jump_target;
                    end
                    stage <= ST_FETCH;
                end
                default: stage <= ST_FETCH;
            endcase
        end
    end

    // bus payload, only loaded while no transfer is open
    always_ff @(posedge i_clk) begin
        if (!o_mem_valid) begin
            if (stage == ST_FETCH) begin
                o_mem_addr <= next_pc;
            end else if (stage == ST_ACCESS) begin
                o_mem_addr <= i_alu_result;
                o_mem_data <= i_rs2_data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (mem_done) begin
            rdata <= i_mem_data;
        end
    end

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    output logic       o_mem_valid,
    input  logic       i_mem_ready,
    output word_t      o_mem_addr,
    input  word_t      i_mem_data,
    output word_t      o_mem_data,
    output logic [3:0] o_mem_wen
);

    word_t    rs1_data;
    word_t    rs2_data;
    logic     rf_we;
    reg_idx_t rf_widx;
    word_t    rf_wdata;
    logic     decode_en;
    logic     prepare_en;
    logic     execute_en;
    word_t    pc;
    word_t    alu_result;
    logic     eq;
    logic     ge;
    logic     geu;

    rv_decode_if dec_if ();

    rv_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .dec          (dec_if.sequencer),
        .i_rs2_data   (rs2_data),
        .o_rf_we      (rf_we),
        .o_rf_widx    (rf_widx),
        .o_rf_wdata   (rf_wdata),
        .o_decode_en  (decode_en),
        .o_prepare_en (prepare_en),
        .o_execute_en (execute_en),
        .o_pc         (pc),
        .i_alu_result (alu_result),
        .i_eq         (eq),
        .i_ge         (ge),
        .i_geu        (geu),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .o_mem_addr   (o_mem_addr),
        .i_mem_data   (i_mem_data),
        .o_mem_data   (o_mem_data),
        .o_mem_wen    (o_mem_wen)
    );

    // instruction word is captured straight off the bus in the ready cycle
    rv_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_decode_en (decode_en),
        .i_instr     (i_mem_data),
        .dec         (dec_if.decoder)
    );

    rv_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_ra      (dec_if.rs1),
        .i_rb      (dec_if.rs2),
        .o_rdata_a (rs1_data),
        .o_rdata_b (rs2_data),
        .i_we      (rf_we),
        .i_widx    (rf_widx),
        .i_wdata   (rf_wdata)
    );

    rv_alu u_alu (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .dec          (dec_if.alu),
        .i_prepare_en (prepare_en),
        .i_execute_en (execute_en),
        .i_pc         (pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_result     (alu_result),
        .o_eq         (eq),
        .o_ge         (ge),
        .o_geu        (geu)
    );

endmodule

// File: bench/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva
    import rv_core_pkg::*;
(
    input logic       i_clk,
    input logic       i_rst,
    input logic       o_mem_valid,
    input logic       i_mem_ready,
    input word_t      o_mem_addr,
    input word_t      o_mem_data,
    input logic [3:0] o_mem_wen
);

    property p_request_held;
        @(posedge i_clk) disable iff (i_rst)
        (o_mem_valid && !i_mem_ready) |=>
            (o_mem_valid && $stable(o_mem_addr) && $stable(o_mem_wen));
    endproperty

    // write data only matters on stores
    property p_write_data_held;
        @(posedge i_clk) disable iff (i_rst)
        (o_mem_valid && !i_mem_ready && o_mem_wen != 4'h0) |=> $stable(o_mem_data);
    endproperty

    property p_wen_with_valid;
        @(posedge i_clk) disable iff (i_rst)
        (o_mem_wen != 4'h0) |-> o_mem_valid;
    endproperty

    property p_word_aligned;
        @(posedge i_clk) disable iff (i_rst)
        o_mem_valid |-> (o_mem_addr[1:0] == 2'b00);
    endproperty

    a_request_held: assert property (p_request_held)
        else $error("bus request changed before ready");
    a_write_data_held: assert property (p_write_data_held)
        else $error("store data changed before ready");
    a_wen_with_valid: assert property (p_wen_with_valid)
        else $error("write enable raised without valid");
    a_word_aligned: assert property (p_word_aligned)
        else $error("bus address not word aligned");

endmodule

bind rv_core_top rv_core_sva u_bus_sva (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_mem_valid (o_mem_valid),
    .i_mem_ready (i_mem_ready),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data),
    .o_mem_wen   (o_mem_wen)
);

// File: bench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int    MEM_WORDS = 2048;
    localparam int    TIMEOUT   = 20000;
    localparam word_t SEED      = 32'he77f_2671;
    localparam word_t DATA_BASE = `RV_PC_RESET + 32'h1000;
    localparam word_t DONE_ADDR = DATA_BASE + 32'h400;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    logic       i_clk;
    logic       i_rst;
    logic       o_mem_valid;
    logic       i_mem_ready;
    word_t      o_mem_addr;
    word_t      i_mem_data;
    word_t      o_mem_data;
    logic [3:0] o_mem_wen;

    word_t mem [MEM_WORDS];
    word_t expected [$];   // result words in store order
    word_t wait_lfsr;
    word_t data_lfsr;
    int    wait_left;
    int    emit_idx;
    logic  done_seen;
    int    n_checks;
    int    n_errors;

    rv_core_top i_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .o_mem_valid (o_mem_valid),
        .i_mem_ready (i_mem_ready),
        .o_mem_addr  (o_mem_addr),
        .i_mem_data  (i_mem_data),
        .o_mem_data  (o_mem_data),
        .o_mem_wen   (o_mem_wen)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic word_t lfsr_step(word_t s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic word_t draw_data(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], data_lfsr[0]};
            data_lfsr = lfsr_step(data_lfsr);
        end
        return v;
    endfunction

    function automatic int draw_wait();
        int v;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            v = (v << 1) | int'(wait_lfsr[0]);
            wait_lfsr = lfsr_step(wait_lfsr);
        end
        return v;
    endfunction

    function automatic logic in_range(word_t addr);
        return (addr >= `RV_PC_RESET) && (addr < `RV_PC_RESET + 4 * MEM_WORDS);
    endfunction

    function automatic int word_index(word_t addr);
        return int'((addr - `RV_PC_RESET) >> 2);
    endfunction

    // memory model with 0 to 3 wait cycles per transfer
    always @(posedge i_clk) begin
        if (i_rst) begin
            i_mem_ready <= 1'b0;
            wait_left = draw_wait();
        end else if (i_mem_ready) begin
            i_mem_ready <= 1'b0;   // handshake closes at this edge
            wait_left = draw_wait();
        end else if (o_mem_valid) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                i_mem_ready <= 1'b1;
                if (!in_range(o_mem_addr)) begin
                    $display("ERROR %0t: bus access outside memory at %h", $time, o_mem_addr);
                    n_errors++;
                    i_mem_data <= '0;
                end else if (o_mem_wen == 4'hf) begin
                    mem[word_index(o_mem_addr)] = o_mem_data;
                    if (o_mem_addr == DONE_ADDR) begin
                        done_seen <= 1'b1;
                    end
                end else if (o_mem_wen == 4'h0) begin
                    i_mem_data <= mem[word_index(o_mem_addr)];
                end else begin
                    $display("ERROR %0t: partial write enable %b on the bus", $time, o_mem_wen);
                    n_errors++;
                end
            end
        end
    end

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t emit_addr();
        return `RV_PC_RESET + word_t'(4 * emit_idx);
    endfunction

    task automatic emit(word_t w);
        mem[emit_idx] = w;
        emit_idx++;
    endtask

    task automatic emit_li(logic [4:0] rd, word_t v);
        word_t up;
        up = v + 32'h800;   // addi sign-extends the low part
        emit(enc_u(up[31:12], rd, OP_LUI));
        emit(enc_i(v[11:0], rd, 3'b000, rd, OP_OP_IMM));
    endtask

    task automatic emit_sw(logic [4:0] rs2, logic [11:0] off);
        emit({off[11:5], rs2, 5'd1, 3'b010, off[4:0], OP_STORE});   // base in x1
    endtask

    task automatic expect_store(logic [4:0] rs, word_t v);
        emit_sw(rs, 12'(4 * expected.size()));
        expected.push_back(v);
    endtask

    task automatic emit_finish();
        emit_sw(5'd0, 12'h400);
        emit(enc_j(21'd0, 5'd0));   // spin
    endtask

    function automatic word_t model_op(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = word_t'($signed(a) < $signed(b));
            3'd3: r = word_t'(a < b);
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t x, word_t y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic logic [2:0] branch_f3(int i);
        case (i)
            0: return 3'd0;
            1: return 3'd1;
            2: return 3'd4;
            3: return 3'd5;
            4: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    task automatic check_value(string name, word_t got, word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic start_test();
        @(posedge i_clk);
        i_rst <= 1'b1;
        @(negedge i_clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (`RV_PC_RESET + 4 * i) ^ 32'h5eed_c0de;
        end
        emit_idx  = 0;
        done_seen = 1'b0;
        expected.delete();
    endtask

    task automatic run_program();
        int cycles;
        repeat (7) @(posedge i_clk);
        @(negedge i_clk);
        check_value("o_mem_valid in reset", o_mem_valid, '0);
        check_value("o_mem_wen in reset", o_mem_wen, '0);
        @(posedge i_clk);
        i_rst <= 1'b0;
        cycles = 0;
        @(negedge i_clk);
        while (!o_mem_valid && cycles < 10) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_mem_valid) begin
            $display("ERROR %0t: no fetch after reset", $time);
            n_errors++;
        end else begin
            check_value("cycles to first fetch", cycles, 1);
            check_value("o_mem_addr first fetch", o_mem_addr, `RV_PC_RESET);
        end
        cycles = 0;
        while (!done_seen && cycles < TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!done_seen) begin
            $display("ERROR %0t: program never stored to the done address", $time);
            n_errors++;
        end
    endtask

    task automatic check_results(string tag);
        word_t addr;
        for (int i = 0; i < expected.size(); i++) begin
            addr = DATA_BASE + 4 * i;
            check_value($sformatf("mem[%h] %s #%0d", addr, tag, i),
                        mem[word_index(addr)], expected[i]);
        end
    endtask

    task automatic test_alu();
        word_t       a;
        word_t       b;
        word_t       b_i;
        logic [11:0] imm;
        logic [11:0] field;
        logic [4:0]  shamt;
        logic        is_shift;
        start_test();
        a     = draw_data(32);
        b     = draw_data(32);
        imm   = 12'(draw_data(12));
        shamt = 5'(draw_data(5));
        emit_li(1, DATA_BASE);
        emit_li(2, a);
        emit_li(3, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            emit(enc_r(7'h00, 3, 2, 3'(f3), 4));
            expect_store(4, model_op(3'(f3), 1'b0, a, b));
        end
        emit(enc_r(7'h20, 3, 2, 3'd0, 4));   // sub
        expect_store(4, model_op(3'd0, 1'b1, a, b));
        emit(enc_r(7'h20, 3, 2, 3'd5, 4));   // sra
        expect_store(4, model_op(3'd5, 1'b1, a, b));
        for (int f3 = 0; f3 < 8; f3++) begin
            is_shift = (f3 == 1) || (f3 == 5);
            field    = is_shift ? {7'h00, shamt} : imm;
            b_i      = is_shift ? word_t'(shamt) : {{20{imm[11]}}, imm};
            emit(enc_i(field, 2, 3'(f3), 4, OP_OP_IMM));
            expect_store(4, model_op(3'(f3), 1'b0, a, b_i));
        end
        emit(enc_i({7'h20, shamt}, 2, 3'd5, 4, OP_OP_IMM));   // srai
        expect_store(4, model_op(3'd5, 1'b1, a, word_t'(shamt)));
        emit_finish();
        run_program();
        check_results("alu");
    endtask

    task automatic test_branches();
        word_t      a;
        word_t      b;
        logic [4:0] r1;
        logic [4:0] r2;
        logic [2:0] f3;
        logic       taken;
        start_test();
        a = draw_data(32) | 32'h8000_0000;   // negative and above b when unsigned
        b = draw_data(32) & 32'h7fff_ffff;
        emit_li(1, DATA_BASE);
        emit_li(2, a);
        emit_li(3, b);
        emit(enc_i(12'h000, 2, 3'b000, 5, OP_OP_IMM));   // x5 = x2
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                f3    = branch_f3(c);
                r1    = (p == 1) ? 5'd3 : 5'd2;
                r2    = (p == 0) ? 5'd3 : ((p == 1) ? 5'd2 : 5'd5);
                taken = branch_taken(f3, (p == 1) ? b : a, (p == 0) ? b : a);
                emit(enc_i(12'h07a, 0, 3'b000, 6, OP_OP_IMM));
                emit(enc_b(13'd8, r2, r1, f3));
                emit(enc_i(12'h04e, 0, 3'b000, 6, OP_OP_IMM));   // fall-through path
                expect_store(6, taken ? 32'h7a : 32'h4e);
            end
        end
        emit_finish();
        run_program();
        check_results("branch");
    endtask

    task automatic test_jumps();
        word_t upper;
        word_t pc_auipc;
        word_t pc_jal;
        word_t pc_li;
        start_test();
        upper = draw_data(20);
        emit_li(1, DATA_BASE);
        emit(enc_i(12'h111, 0, 3'b000, 9, OP_OP_IMM));
        emit(enc_i(12'h300, 0, 3'b000, 12, OP_OP_IMM));
        pc_auipc = emit_addr();
        emit(enc_u(upper[19:0], 7, OP_AUIPC));
        expect_store(7, pc_auipc + {upper[19:0], 12'h000});
        pc_jal = emit_addr();
        emit(enc_j(21'd12, 8));
        emit(enc_i(12'h222, 0, 3'b000, 9, OP_OP_IMM));
        emit(enc_i(12'h555, 0, 3'b000, 9, OP_OP_IMM));
        emit(enc_i(12'h010, 9, 3'b000, 9, OP_OP_IMM));   // jal target
        expect_store(8, pc_jal + 4);
        expect_store(9, 32'h121);
        pc_li = emit_addr();
        emit_li(10, pc_li + 16 + 2);   // odd sum after -1 so bit 0 is dropped
        emit(enc_i(12'hfff, 10, 3'b000, 11, OP_JALR));
        emit(enc_i(12'h333, 0, 3'b000, 12, OP_OP_IMM));
        emit(enc_i(12'h044, 12, 3'b000, 12, OP_OP_IMM));   // jalr target
        expect_store(11, pc_li + 12);
        expect_store(12, 32'h344);
        emit_finish();
        run_program();
        check_results("jump");
    endtask

    task automatic test_memory();
        word_t d0;
        word_t d1;
        start_test();
        d0 = draw_data(32);
        d1 = draw_data(32);
        mem[word_index(DATA_BASE + 32'h200)] = d0;
        mem[word_index(DATA_BASE + 32'h204)] = d1;
        emit_li(1, DATA_BASE);
        emit(enc_i(12'h200, 1, 3'b010, 13, OP_LOAD));
        expect_store(13, d0);
        emit(enc_i(12'h204, 1, 3'b010, 14, OP_LOAD));
        expect_store(14, d1);
        emit(enc_i(12'h5a5, 13, 3'b000, 0, OP_OP_IMM));   // writes to x0
        emit(enc_u(20'hfffff, 0, OP_LUI));
        expect_store(0, 32'h0);
        emit({20'h12345, 5'd13, 7'h7f});   // unknown opcode leaves x13 untouched
        expect_store(13, d0);
        emit_finish();
        run_program();
        check_results("load store");
    endtask

    initial begin
        i_rst       = 1'b1;
        i_mem_ready = 1'b0;
        i_mem_data  = '0;
        n_checks    = 0;
        n_errors    = 0;
        wait_lfsr   = SEED;
        data_lfsr   = SEED;
        emit_idx    = 0;
        done_seen   = 1'b0;
        test_alu();
        test_branches();
        test_jumps();
        test_memory();
        finish_run();
    end

endmodule

// File: files.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_decode_if.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_sequencer.sv
source/rv_core_top.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv
